// File: uart_pkg.sv
////////////////////////////////////////////////////////////
// shared sizes, register map and FSM state encodings
// for the UART peripheral
////////////////////////////////////////////////////////////

package uart_pkg;

    // character and timing widths
    localparam int unsigned uart_dw = 8;   // data bits per character
    localparam int unsigned uart_rw = 16;  // baud/sample counter width

    // FIFO geometry
    localparam int unsigned fifo_sz = 16;  // entries
    localparam int unsigned fifo_aw = 4;   // pointer width
    localparam int unsigned fifo_cw = 5;   // load count width, holds 0..fifo_sz

    // system bus
    localparam int unsigned sys_adr = 4;
    localparam int unsigned sys_dat = 32;

    // register map, TX in the low half, RX in the high half
    typedef enum logic [sys_adr-1:0] {
        tx_data    = 4'h0,  // push only
        tx_load    = 4'h1,  // TX FIFO load, read only
        tx_baud    = 4'h2,
        tx_irq_lvl = 4'h4,
        rx_data    = 4'h8,  // read pops
        rx_load    = 4'h9,  // RX FIFO load, read only
        rx_baud    = 4'ha,
        rx_smp     = 4'hb,  // start bit sample delay
        rx_irq_lvl = 4'hc
    } reg_addr_e;

    // serializer FSM
    typedef enum logic [1:0] {
        ser_idle,
        ser_start,
        ser_data,
        ser_stop
    } ser_state_e;

    // deserializer FSM
    typedef enum logic [1:0] {
        des_idle,
        des_start,
        des_data,
        des_stop
    } des_state_e;

endpackage : uart_pkg

// File: uart_cfg_if.sv
////////////////////////////////////////////////////////////
// configuration bundle from register block to ser/des
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface uart_cfg_if import uart_pkg::*; ();

    logic [uart_rw-1:0] tx_bdr;  // TX bit period minus one
    logic [fifo_cw-1:0] tx_irq;  // TX irq level
    logic [uart_rw-1:0] rx_bdr;  // RX bit period minus one
    logic [uart_rw-1:0] rx_smp;  // RX start sample delay minus one
    logic [fifo_cw-1:0] rx_irq;  // RX irq level

    // register block owns everything
    modport regs (output tx_bdr, tx_irq, rx_bdr, rx_smp, rx_irq);

    // serializer only needs its baud period
    modport tx (input tx_bdr);

    // deserializer needs period and sample phase
    modport rx (input rx_bdr, rx_smp);

endinterface : uart_cfg_if

// File: uart_regs.sv
////////////////////////////////////////////////////////////
// bus decode, config registers, FIFO strobes, read mux, irqs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_regs import uart_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // bus write port
    input  logic               sys_wen,
    input  logic [sys_adr-1:0] sys_wad,
    input  logic [sys_dat-1:0] sys_wdt,
    // bus read port
    input  logic               sys_ren,
    input  logic [sys_adr-1:0] sys_rad,
    output logic [sys_dat-1:0] sys_rdt,
    // stream into TX FIFO
    output logic               tx_vld,
    output logic [uart_dw-1:0] tx_dat,
    // stream out of RX FIFO
    input  logic               rx_vld,
    input  logic [uart_dw-1:0] rx_dat,
    output logic               rx_rdy,
    // FIFO loads
    input  logic [fifo_cw-1:0] tx_cnt,
    input  logic [fifo_cw-1:0] rx_cnt,
    // interrupts
    output logic               irq_tx,
    output logic               irq_rx,
    // configuration out
    uart_cfg_if.regs           cfg
);

    reg_addr_e wadr;  // decoded write address
    reg_addr_e radr;  // decoded read address

    assign wadr = reg_addr_e'(sys_wad);
    assign radr = reg_addr_e'(sys_rad);

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg.tx_bdr <= '0;
            cfg.tx_irq <= '0;
            cfg.rx_bdr <= '0;
            cfg.rx_smp <= '0;
            cfg.rx_irq <= '0;
        end else if (sys_wen) begin
            case (wadr)
                tx_baud:    cfg.tx_bdr <= sys_wdt[uart_rw-1:0];
                tx_irq_lvl: cfg.tx_irq <= sys_wdt[fifo_cw-1:0];
                rx_baud:    cfg.rx_bdr <= sys_wdt[uart_rw-1:0];
                rx_smp:     cfg.rx_smp <= sys_wdt[uart_rw-1:0];
                rx_irq_lvl: cfg.rx_irq <= sys_wdt[fifo_cw-1:0];
                default:    ;  // data, load and holes ignored
            endcase
        end
    end

    // TX data write becomes a push, FIFO drops it when full
    assign tx_vld = sys_wen && (wadr == tx_data);
    assign tx_dat = sys_wdt[uart_dw-1:0];

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (radr)
            tx_load:    sys_rdt = sys_dat'(tx_cnt);
            tx_baud:    sys_rdt = sys_dat'(cfg.tx_bdr);
            tx_irq_lvl: sys_rdt = sys_dat'(cfg.tx_irq);
            rx_data:    sys_rdt = rx_vld ? sys_dat'(rx_dat) : '0;  // zero when empty
            rx_load:    sys_rdt = sys_dat'(rx_cnt);
            rx_baud:    sys_rdt = sys_dat'(cfg.rx_bdr);
            rx_smp:     sys_rdt = sys_dat'(cfg.rx_smp);
            rx_irq_lvl: sys_rdt = sys_dat'(cfg.rx_irq);
            default:    sys_rdt = '0;  // tx_data and holes
        endcase
    end

    // reading RX data pops the head
    assign rx_rdy = sys_ren && (radr == rx_data);

    ////////////////////////////////////////////////////////////
    // interrupts
    ////////////////////////////////////////////////////////////

    assign irq_tx = (tx_cnt < cfg.tx_irq);  // room for more TX data
    assign irq_rx = (rx_cnt > cfg.rx_irq);  // RX data waiting

endmodule : uart_regs

// File: uart_fifo.sv
////////////////////////////////////////////////////////////
// FWFT FIFO, valid/ready both sides, load count
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // input stream
    input  logic               sti_vld,
    input  logic [uart_dw-1:0] sti_dat,
    output logic               sti_rdy,
    // output stream
    output logic               sto_vld,
    output logic [uart_dw-1:0] sto_dat,
    input  logic               sto_rdy,
    // load
    output logic [fifo_cw-1:0] cnt
);

    logic [uart_dw-1:0] mem [fifo_sz];
    logic [fifo_aw-1:0] wptr;
    logic [fifo_aw-1:0] rptr;
    logic               push;
    logic               pop;

    assign sti_rdy = (cnt != fifo_cw'(fifo_sz));  // not full
    assign sto_vld = (cnt != '0);                  // not empty

    assign push = sti_vld && sti_rdy;
    assign pop  = sto_vld && sto_rdy;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
            cnt  <= '0;
        end else begin
            if (push) wptr <= wptr + 1'b1;
            if (pop)  rptr <= rptr + 1'b1;
            // push and pop together leave the load as is
            if (push && !pop) cnt <= cnt + 1'b1;
            else if (pop && !push) cnt <= cnt - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) mem[wptr] <= sti_dat;
    end

    assign sto_dat = mem[rptr];  // head straight from memory

endmodule : uart_fifo

// File: uart_ser.sv
////////////////////////////////////////////////////////////
// 8N1 transmit serializer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_ser import uart_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // parallel stream in
    input  logic               str_vld,
    input  logic [uart_dw-1:0] str_dat,
    output logic               str_rdy,
    // serial out
    output logic               txd,
    uart_cfg_if.tx             cfg
);

    ser_state_e                 state;
    logic [uart_rw-1:0]         bdr_cnt;  // cycles within a bit
    logic [$clog2(uart_dw)-1:0] bit_idx;  // data bit number
    logic [uart_dw-1:0]         shr;      // outgoing bits, LSB first
    logic                       bit_end;  // last cycle of current bit
    logic                       accept;

    assign str_rdy = (state == ser_idle);
    assign accept  = str_vld && str_rdy;
    assign bit_end = (bdr_cnt == cfg.tx_bdr);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= ser_idle;
            bdr_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;  // line idles high
        end else begin
            bdr_cnt <= (state == ser_idle || bit_end) ? '0 : bdr_cnt + 1'b1;
            case (state)
                ser_idle: if (accept) begin
                    state <= ser_start;
                    txd   <= 1'b0;  // start bit
                end
                ser_start: if (bit_end) begin
                    state   <= ser_data;
                    bit_idx <= '0;
                    txd     <= shr[0];
                end
                ser_data: if (bit_end) begin
                    if (int'(bit_idx) == uart_dw - 1) begin
                        state <= ser_stop;
                        txd   <= 1'b1;  // stop bit
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        txd     <= shr[0];
                    end
                end
                ser_stop: if (bit_end) state <= ser_idle;
                default: state <= ser_idle;
            endcase
        end
    end

    // shift register, load on accept, shift as each bit goes out
    always_ff @(posedge clk) begin
        if (accept) shr <= str_dat;
        else if (bit_end && (state == ser_start || state == ser_data)) shr <= shr >> 1;
    end

endmodule : uart_ser

// File: uart_des.sv
////////////////////////////////////////////////////////////
// 8N1 receive deserializer
// start detect, sample phase, stop bit check
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_des import uart_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // serial in, asynchronous to clk
    input  logic               rxd,
    // parallel stream out, no back-pressure
    output logic               str_vld,
    output logic [uart_dw-1:0] str_dat,
    uart_cfg_if.rx             cfg
);

    logic [1:0]                 rxd_sync;  // two flop synchronizer
    logic                       rxd_dly;   // previous synced value
    logic                       rxd_s;     // synced rxd
    logic                       rxd_fall;  // start candidate
    des_state_e                 state;
    logic [uart_rw-1:0]         phs_cnt;   // sample delay, then bit period
    logic [$clog2(uart_dw)-1:0] bit_idx;
    logic [uart_dw-1:0]         shr;       // incoming bits
    logic                       smp_hit;   // sample moment reached

    ////////////////////////////////////////////////////////////
    // input synchronizer and edge detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rxd_sync <= 2'b11;  // idle high
            rxd_dly  <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rxd_dly  <= rxd_s;
        end
    end

    assign rxd_s    = rxd_sync[1];
    assign rxd_fall = rxd_dly && !rxd_s;

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////

    // start state waits the sample delay, others a full bit
    assign smp_hit = (state == des_start) ? (phs_cnt == cfg.rx_smp)
                                          : (phs_cnt == cfg.rx_bdr);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= des_idle;
            phs_cnt <= '0;
            bit_idx <= '0;
            str_vld <= 1'b0;
        end else begin
            str_vld <= 1'b0;  // single cycle pulse
            phs_cnt <= (state == des_idle || smp_hit) ? '0 : phs_cnt + 1'b1;
            case (state)
                des_idle: if (rxd_fall) state <= des_start;
                des_start: if (smp_hit) begin
                    bit_idx <= '0;
                    // glitch guard, start bit must still be low
                    state   <= rxd_s ? des_idle : des_data;
                end
                des_data: if (smp_hit) begin
                    if (int'(bit_idx) == uart_dw - 1) state <= des_stop;
                    else bit_idx <= bit_idx + 1'b1;
                end
                des_stop: if (smp_hit) begin
                    state   <= des_idle;
                    str_vld <= rxd_s;  // bad stop bit, frame dropped
                end
                default: state <= des_idle;
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == des_data && smp_hit) shr <= {rxd_s, shr[uart_dw-1:1]};
    end

    assign str_dat = shr;  // stable from last data bit until next frame

endmodule : uart_des

// File: uart_peri.sv
////////////////////////////////////////////////////////////
// UART peripheral top, regs + FIFOs + ser/des wiring
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_peri import uart_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // serial lines
    input  logic               uart_rxd,
    output logic               uart_txd,
    // bus write
    input  logic               sys_wen,
    input  logic [sys_adr-1:0] sys_wad,
    input  logic [sys_dat-1:0] sys_wdt,
    // bus read
    input  logic               sys_ren,
    input  logic [sys_adr-1:0] sys_rad,
    output logic [sys_dat-1:0] sys_rdt,
    // interrupts
    output logic               irq_tx,
    output logic               irq_rx
);

    // regs -> TX FIFO
    logic               tx_bus_vld;
    logic [uart_dw-1:0] tx_bus_dat;
    // TX FIFO -> serializer
    logic               tx_str_vld;
    logic [uart_dw-1:0] tx_str_dat;
    logic               tx_str_rdy;
    // deserializer -> RX FIFO
    logic               rx_str_vld;
    logic [uart_dw-1:0] rx_str_dat;
    // RX FIFO -> regs
    logic               rx_bus_vld;
    logic [uart_dw-1:0] rx_bus_dat;
    logic               rx_bus_rdy;
    // loads
    logic [fifo_cw-1:0] tx_cnt;
    logic [fifo_cw-1:0] rx_cnt;

    uart_cfg_if u_cfg ();

    uart_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .sys_wen (sys_wen),
        .sys_wad (sys_wad),
        .sys_wdt (sys_wdt),
        .sys_ren (sys_ren),
        .sys_rad (sys_rad),
        .sys_rdt (sys_rdt),
        .tx_vld  (tx_bus_vld),
        .tx_dat  (tx_bus_dat),
        .rx_vld  (rx_bus_vld),
        .rx_dat  (rx_bus_dat),
        .rx_rdy  (rx_bus_rdy),
        .tx_cnt  (tx_cnt),
        .rx_cnt  (rx_cnt),
        .irq_tx  (irq_tx),
        .irq_rx  (irq_rx),
        .cfg     (u_cfg.regs)
    );

    // full TX FIFO silently drops bus writes
    uart_fifo tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .sti_vld (tx_bus_vld),
        .sti_dat (tx_bus_dat),
        .sti_rdy (),
        .sto_vld (tx_str_vld),
        .sto_dat (tx_str_dat),
        .sto_rdy (tx_str_rdy),
        .cnt     (tx_cnt)
    );

    uart_ser tx_ser (
        .clk     (clk),
        .rst     (rst),
        .str_vld (tx_str_vld),
        .str_dat (tx_str_dat),
        .str_rdy (tx_str_rdy),
        .txd     (uart_txd),
        .cfg     (u_cfg.tx)
    );

    // full RX FIFO loses incoming bytes
    uart_fifo rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .sti_vld (rx_str_vld),
        .sti_dat (rx_str_dat),
        .sti_rdy (),
        .sto_vld (rx_bus_vld),
        .sto_dat (rx_bus_dat),
        .sto_rdy (rx_bus_rdy),
        .cnt     (rx_cnt)
    );

    uart_des rx_des (
        .clk     (clk),
        .rst     (rst),
        .rxd     (uart_rxd),
        .str_vld (rx_str_vld),
        .str_dat (rx_str_dat),
        .cfg     (u_cfg.rx)
    );

endmodule : uart_peri

// File: tb_uart_peri.sv
////////////////////////////////////////////////////////////
// directed testbench for the UART peripheral
// bus tasks, serial monitor, loopback and checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_uart_peri import uart_pkg::*; ();

    localparam int unsigned clk_per    = 100;
    localparam int unsigned max_cycles = 40000;  // all tests take roughly 7k cycles

    logic               clk;
    logic               rst;
    logic               uart_rxd;
    logic               uart_txd;
    logic               sys_wen;
    logic [sys_adr-1:0] sys_wad;
    logic [sys_dat-1:0] sys_wdt;
    logic               sys_ren;
    logic [sys_adr-1:0] sys_rad;
    logic [sys_dat-1:0] sys_rdt;
    logic               irq_tx;
    logic               irq_rx;

    logic               loop_en;      // txd fed back into rxd
    int unsigned        cyc = 0;
    int unsigned        bit_len;      // current bit period in cycles
    logic [31:0]        rng;          // xorshift state
    logic [uart_dw-1:0] exp_q [$];    // bytes expected back on RX

    assign uart_rxd = loop_en ? uart_txd : 1'b1;  // idle high when open

    uart_peri u_uart_peri (
        .clk      (clk),
        .rst      (rst),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .sys_wen  (sys_wen),
        .sys_wad  (sys_wad),
        .sys_wdt  (sys_wdt),
        .sys_ren  (sys_ren),
        .sys_rad  (sys_rad),
        .sys_rdt  (sys_rdt),
        .irq_tx   (irq_tx),
        .irq_rx   (irq_rx)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_per / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // called 10 ns after an edge and returns 10 ns after the write edge
    task automatic bus_write(input logic [sys_adr-1:0] adr, input logic [sys_dat-1:0] dat);
        sys_wen = 1'b1;
        sys_wad = adr;
        sys_wdt = dat;
        @(posedge clk);
        #10;
        sys_wen = 1'b0;
    endtask

    task automatic bus_read(input logic [sys_adr-1:0] adr, input logic pop,
                            output logic [sys_dat-1:0] dat);
        sys_rad = adr;
        sys_ren = pop;
        #30;
        dat = sys_rdt;  // combinational read has settled mid cycle
        @(posedge clk);
        #10;
        sys_ren = 1'b0;
    endtask

    task automatic read_check(input logic [sys_adr-1:0] adr, input logic [sys_dat-1:0] exp,
                              input string what);
        logic [sys_dat-1:0] d;
        bus_read(adr, 1'b0, d);
        check_eq(d, exp, what);
    endtask

    // let the line finish its stop bit before the baud changes
    task automatic set_baud(input int tx_b, input int rx_b, input int smp);
        wait_cycles(2 * bit_len);
        bus_write(tx_baud, 32'(tx_b));
        bus_write(rx_baud, 32'(rx_b));
        bus_write(rx_smp, 32'(smp));
        bit_len = tx_b + 1;
    endtask

    // start bit lands in bit 0 and stop bit in bit 9 of each vector
    task automatic serial_monitor(input int bit_cyc, output logic [9:0] frame,
                                  output logic [9:0] head, output logic [9:0] tail);
        while (uart_txd !== 1'b0) begin
            @(posedge clk);
            #10;
        end
        for (int b = 0; b < 10; b++) begin
            for (int c = 0; c < bit_cyc; c++) begin
                if (c == 0) head = {uart_txd, head[9:1]};              // first cycle of the bit
                if (c == bit_cyc / 2) frame = {uart_txd, frame[9:1]};  // mid-bit sample
                if (c == bit_cyc - 1) tail = {uart_txd, tail[9:1]};    // last cycle of the bit
                @(posedge clk);
                #10;
            end
        end
    endtask

    task automatic wait_rx_load(input int n);
        logic [sys_dat-1:0] d;
        bus_read(rx_load, 1'b0, d);
        while (d != 32'(n)) bus_read(rx_load, 1'b0, d);
    endtask

    // pop n bytes as they arrive and compare with the queue
    task automatic recv_expect(input int n);
        logic [sys_dat-1:0] d;
        int got;
        got = 0;
        while (got < n) begin
            bus_read(rx_load, 1'b0, d);
            if (d != 0) begin
                bus_read(rx_data, 1'b1, d);
                check_eq(d, 32'(exp_q.pop_front()), "loopback byte");
                got++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_cfg();
        for (int a = 0; a < 16; a++) read_check(sys_adr'(a), 0, "register after reset");
        check_eq(32'(uart_txd), 1, "txd idle after reset");
        check_eq(32'(irq_tx), 0, "irq_tx after reset");
        check_eq(32'(irq_rx), 0, "irq_rx after reset");
        bus_write(tx_baud, 32'hdead_1234);     // upper bits beyond the field width
        bus_write(tx_irq_lvl, 32'hffff_ffeb);
        bus_write(rx_baud, 32'h0000_5678);
        bus_write(rx_smp, 32'h0001_2b3c);
        bus_write(rx_irq_lvl, 32'h0000_0011);
        bus_write(tx_load, 32'h0000_00ff);     // read only
        bus_write(rx_load, 32'h0000_00ff);
        read_check(tx_baud, 32'h0000_1234, "tx_baud readback");
        read_check(tx_irq_lvl, 32'h0000_000b, "tx_irq_lvl readback");
        read_check(rx_baud, 32'h0000_5678, "rx_baud readback");
        read_check(rx_smp, 32'h0000_2b3c, "rx_smp readback");
        read_check(rx_irq_lvl, 32'h0000_0011, "rx_irq_lvl readback");
        read_check(tx_load, 0, "tx_load after write");
        read_check(rx_load, 0, "rx_load after write");
    endtask

    task automatic test_tx_frame();
        logic [uart_dw-1:0] msg [$];
        logic [9:0]         frame;
        logic [9:0]         head;
        logic [9:0]         tail;
        msg = '{8'h35, 8'hca};
        loop_en = 1'b0;
        set_baud(7, 7, 3);
        foreach (msg[i]) begin
            bus_write(tx_data, 32'(msg[i]));
            serial_monitor(8, frame, head, tail);  // 8 cycles per bit at baud 7
            check_eq(32'(frame), 32'({1'b1, msg[i], 1'b0}), "8N1 frame on txd");
            check_eq(32'(head), 32'({1'b1, msg[i], 1'b0}), "txd at start of each bit");
            check_eq(32'(tail), 32'({1'b1, msg[i], 1'b0}), "txd at end of each bit");
        end
        read_check(rx_load, 0, "nothing received with loopback open");
    endtask

    task automatic test_loopback();
        logic [uart_dw-1:0] msg [$];
        logic [sys_dat-1:0] d;
        msg = '{8'h11, 8'h5a, 8'ha5, 8'hf0};
        loop_en = 1'b1;
        foreach (msg[i]) begin
            bus_write(tx_data, 32'(msg[i]));
            exp_q.push_back(msg[i]);
        end
        wait_cycles(4 * 10 * bit_len + 2 * bit_len);  // four frames plus sync latency
        read_check(rx_load, 4, "rx_load after four frames");
        for (int i = 0; i < 4; i++) begin
            bus_read(rx_data, 1'b1, d);
            check_eq(d, 32'(exp_q.pop_front()), "loopback byte in order");
            read_check(rx_load, 32'(3 - i), "rx_load while draining");
        end
        bus_read(rx_data, 1'b1, d);
        check_eq(d, 0, "rx_data read when empty");
        read_check(rx_load, 0, "rx_load after empty read");
    endtask

    task automatic test_irq();
        logic [uart_dw-1:0] msg [$];
        logic [sys_dat-1:0] d;
        msg = '{8'h01, 8'h82, 8'h7e, 8'hc3};
        set_baud(31, 31, 15);  // long frames keep the serializer busy
        bus_write(tx_irq_lvl, 3);
        bus_write(rx_irq_lvl, 1);
        check_eq(32'(irq_tx), 1, "irq_tx with empty TX FIFO");
        bus_write(tx_data, 32'(msg[0]));
        exp_q.push_back(msg[0]);
        wait_cycles(2);  // serializer takes the first byte
        read_check(tx_load, 0, "tx_load with byte in serializer");
        for (int i = 1; i < 4; i++) begin
            bus_write(tx_data, 32'(msg[i]));
            exp_q.push_back(msg[i]);
            check_eq(32'(irq_tx), 32'(i < 3), "irq_tx against TX load");
            read_check(tx_load, 32'(i), "tx_load while queued");
        end
        wait_rx_load(1);
        check_eq(32'(irq_rx), 0, "irq_rx with one byte");
        wait_rx_load(2);
        check_eq(32'(irq_rx), 1, "irq_rx with two bytes");
        bus_read(rx_data, 1'b1, d);
        check_eq(d, 32'(exp_q.pop_front()), "first irq byte");
        check_eq(32'(irq_rx), 0, "irq_rx after one read");
        recv_expect(3);
    endtask

    task automatic test_overflow();
        logic [uart_dw-1:0] b;
        logic [sys_dat-1:0] d;
        set_baud(15, 15, 7);
        for (int i = 0; i < 20; i++) begin
            b = uart_dw'(8'h40 + i);
            bus_write(tx_data, 32'(b));
            if (i <= fifo_sz) exp_q.push_back(b);  // one in the serializer plus a full FIFO
        end
        bus_read(tx_load, 1'b0, d);
        check_eq(32'(d <= fifo_sz), 1, "tx_load bounded by FIFO depth");
        recv_expect(fifo_sz + 1);
        wait_cycles(2 * 10 * bit_len);
        read_check(rx_load, 0, "no extra bytes after overflow");
        read_check(tx_load, 0, "TX FIFO drained");
    endtask

    task automatic test_random();
        int bauds [$];
        bauds = '{3, 10};
        foreach (bauds[k]) begin
            set_baud(bauds[k], bauds[k], bauds[k] / 2);
            for (int i = 0; i < 12; i++) begin
                rng = xorshift(rng);
                bus_write(tx_data, 32'(rng[7:0]));
                exp_q.push_back(rng[7:0]);
            end
            recv_expect(12);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst     = 1'b1;
        sys_wen = 1'b0;
        sys_wad = '0;
        sys_wdt = '0;
        sys_ren = 1'b0;
        sys_rad = '0;
        loop_en = 1'b0;
        rng     = 32'd88;
        bit_len = 1;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        test_reset_cfg();
        test_tx_frame();
        test_loopback();
        test_irq();
        test_overflow();
        test_random();
        $display("TEST PASSED");
        $finish;
    end

endmodule : tb_uart_peri

// File: uart_peri.f
uart_pkg.sv
uart_cfg_if.sv
uart_regs.sv
uart_fifo.sv
uart_ser.sv
uart_des.sv
uart_peri.sv
tb_uart_peri.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the UART peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_uart_peri -f uart_peri.f -o tb_uart_peri
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_uart_peri > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished cleanly"
exit 0
